//--- tb_input.txt
# kind a b, values in hex: wr addr data | rd addr expected | col index word
# gclk expected_blank divider | drain 0 0 waits for all columns to latch
gclk 1 0
rd 01 03
wr 01 05
rd 01 05
rd 7f 00
col 5 a1b2c3
drain 0 0
col 0 ff0081
col 3 123456
col 6 00ff00
col 7 5a5aa5
drain 0 0
wr 01 02
wr 00 01
rd 00 01
gclk 0 02
wr 00 00
rd 00 00
gclk 1 0

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_pov \
    -o tb_pov_sim && \
./obj_dir/tb_pov_sim | tee /dev/stderr | grep -Fqx "All checks passed" && \
echo "Simulation result: pass" || { echo "Simulation result: fail"; exit 1; }

//--- sources.f
+incdir+.
pov_pkg.sv
spi_byte_if.sv
col_data_if.sv
spi_frame_rx.sv
cmd_decoder.sv
pov_regs.sv
led_shift_ctrl.sv
pov_top.sv
tb_pov.sv

//--- tb_pov.sv
// *************************************************
// Self-checking testbench for the POV controller
// Replays SPI frames from tb_input.txt, checks the
// readback on miso and every latched driver word
// *************************************************
`timescale 1ns/1ns
`default_nettype none
`include "pov_config.svh"

module tb_pov;

    logic              clk = 1'b0;
    logic              reset;
    logic              spi_sclk;
    logic              spi_cs;
    logic              spi_mosi;
    wire               spi_miso;
    wire               drv_sin;
    wire               drv_sclk;
    wire               drv_lat;
    wire               drv_gclk;
    wire               drv_blank;
    pov_pkg::col_idx_t col_sel;

    // Records from the stimulus file
    string             rec_kind [$];
    logic [31:0]       rec_a [$];
    logic [31:0]       rec_b [$];

    // Columns still waiting for their latch pulse
    pov_pkg::pixel_t   exp_word [$];
    pov_pkg::col_idx_t exp_col [$];

    pov_pkg::byte_t    frame_bytes [5];
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                cycle_limit = 1000;
    pov_pkg::pixel_t   sin_bits = '0;
    int                sclk_edges = 0;
    logic              sclk_prev = 1'b0;

    pov_top i_dut (
        .clk(clk), .reset(reset),
        .spi_sclk(spi_sclk), .spi_cs(spi_cs), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .drv_sin(drv_sin), .drv_sclk(drv_sclk), .drv_lat(drv_lat),
        .drv_gclk(drv_gclk), .drv_blank(drv_blank), .col_sel(col_sel)
    );

    always #4 clk = ~clk;

    // Run limit scales with the number of records
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task report_mismatch(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        errors++;
        $display("Error %s: expected %h, actual %h", name, expected, actual);
    endtask

    // Driver chain monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (drv_sclk && !sclk_prev) begin
                sin_bits = {sin_bits[`POV_COL_BITS-2:0], drv_sin};
                sclk_edges++;
            end
            if (drv_lat) begin
                if (exp_word.size() == 0) begin
                    errors++;
                    $display("Latch pulse came with no column write outstanding");
                end else begin
                    checks += 3;
                    if (sclk_edges != `POV_COL_BITS)
                        report_mismatch("latch bit count", `POV_COL_BITS, sclk_edges);
                    if (sin_bits != exp_word[0])
                        report_mismatch("latch word", exp_word[0], sin_bits);
                    if (col_sel != exp_col[0])
                        report_mismatch("latch column", exp_col[0], col_sel);
                    void'(exp_word.pop_front());
                    void'(exp_col.pop_front());
                end
                sclk_edges = 0;
            end
        end
        sclk_prev = drv_sclk;
    end

    // One SPI mode 0 byte, 4 clk low then 4 clk high per bit
    // Entered right after a rising clk with sclk low
    task send_byte(input pov_pkg::byte_t tx, output pov_pkg::byte_t rx);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi <= tx[i];
            repeat (3) @(posedge clk);
            // Reply bit is settled before the rising sclk
            @(negedge clk);
            rx[i] = spi_miso;
            @(posedge clk);
            spi_sclk <= 1'b1;
            repeat (4) @(posedge clk);
            spi_sclk <= 1'b0;
        end
    endtask

    // Whole frame from frame_bytes, returns the reply seen in the last byte
    task send_frame(input int count, output pov_pkg::byte_t last_reply);
        @(posedge clk);
        spi_cs <= 1'b0;
        repeat (4) @(posedge clk);
        for (int k = 0; k < count; k++)
            send_byte(frame_bytes[k], last_reply);
        repeat (4) @(posedge clk);
        spi_cs <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    // Blanking state and grayscale clock spacing
    task check_gclk(input logic exp_blank, input pov_pkg::byte_t div, input string name);
        int   gap;
        logic prev;
        repeat (4) @(posedge clk);
        @(negedge clk);
        checks++;
        if (drv_blank !== exp_blank)
            report_mismatch({name, " blank"}, exp_blank, drv_blank);
        if (exp_blank) begin
            // Clock must hold low while blanked
            gap = 0;
            repeat (64) begin
                @(negedge clk);
                if (drv_gclk !== 1'b0)
                    gap++;
            end
            checks++;
            if (gap != 0)
                report_mismatch({name, " gclk high cycles"}, 0, gap);
        end else begin
            prev = drv_gclk;
            while (drv_gclk == prev)
                @(negedge clk);
            repeat (2) begin
                gap  = 0;
                prev = drv_gclk;
                do begin
                    @(negedge clk);
                    gap++;
                end while (drv_gclk == prev);
                checks++;
                if (gap != int'(div) + 1)
                    report_mismatch({name, " gclk spacing"}, int'(div) + 1, gap);
            end
        end
    endtask

    // Waits until every written column has latched
    task wait_drain();
        while (exp_word.size() != 0)
            @(negedge clk);
        repeat (4) @(posedge clk);
    endtask

    task run_record(input int idx);
        pov_pkg::byte_t reply;
        string          name;
        name = $sformatf("%s %0d", rec_kind[idx], idx);
        if (rec_kind[idx] == "wr") begin
            frame_bytes[0] = pov_pkg::REG_WRITE;
            frame_bytes[1] = rec_a[idx][7:0];
            frame_bytes[2] = rec_b[idx][7:0];
            send_frame(3, reply);
        end else if (rec_kind[idx] == "rd") begin
            // Third byte is a dummy that clocks the reply out
            frame_bytes[0] = pov_pkg::REG_READ;
            frame_bytes[1] = rec_a[idx][7:0];
            frame_bytes[2] = 8'h00;
            send_frame(3, reply);
            checks++;
            if (reply != rec_b[idx][7:0])
                report_mismatch(name, rec_b[idx][7:0], reply);
        end else if (rec_kind[idx] == "col") begin
            exp_col.push_back(pov_pkg::col_idx_t'(rec_a[idx]));
            exp_word.push_back(pov_pkg::pixel_t'(rec_b[idx]));
            frame_bytes[0] = pov_pkg::COL_WRITE;
            frame_bytes[1] = rec_a[idx][7:0];
            frame_bytes[2] = rec_b[idx][23:16];
            frame_bytes[3] = rec_b[idx][15:8];
            frame_bytes[4] = rec_b[idx][7:0];
            send_frame(5, reply);
        end else if (rec_kind[idx] == "gclk") begin
            check_gclk(rec_a[idx][0], rec_b[idx][7:0], name);
        end else if (rec_kind[idx] == "drain") begin
            wait_drain();
        end else begin
            errors++;
            $display("Unknown record kind %s in the stimulus file", rec_kind[idx]);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [31:0] a_val;
        logic [31:0] b_val;
        reset    = 1'b1;
        spi_sclk = 1'b0;
        spi_cs   = 1'b1;
        spi_mosi = 1'b0;

        // Records are kind plus two hex fields, # starts a comment line
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb_input.txt");
            $display("Checks failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h %h", kind, a_val, b_val) == 3) begin
                        rec_kind.push_back(kind);
                        rec_a.push_back(a_val);
                        rec_b.push_back(b_val);
                    end
                end
            end
            $fclose(fd);
            cycle_limit = rec_kind.size() * 600 + 1000;

            repeat (16) @(posedge clk);
            reset <= 1'b0;
            repeat (4) @(posedge clk);

            foreach (rec_kind[i])
                run_record(i);
            wait_drain();

            $display("Summary: %0d checks, %0d errors", checks, errors);
            if (errors == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- pov_top.sv
// *************************************************
// POV column display controller top level
// SPI host port in, LED driver chain and column
// select out
// *************************************************
`timescale 1ns/1ns
`default_nettype none
`include "pov_config.svh"

module pov_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             spi_sclk,
    input  logic                             spi_cs,
    input  logic                             spi_mosi,
    output logic                             spi_miso,
    output logic                             drv_sin,
    output logic                             drv_sclk,
    output logic                             drv_lat,
    output logic                             drv_gclk,
    output logic                             drv_blank,
    output logic [$clog2(`POV_NUM_COLS)-1:0] col_sel
);

    spi_byte_if spi_bus ();
    col_data_if col_bus ();

    // Register port between decoder and control registers
    logic               reg_wr;
    pov_pkg::reg_addr_t reg_addr;
    pov_pkg::byte_t     reg_wdata;
    pov_pkg::byte_t     reg_rdata;
    logic               display_enable;
    pov_pkg::byte_t     gclk_div;

    spi_frame_rx i_spi_rx (
        .clk(clk), .reset(reset),
        .spi_sclk(spi_sclk), .spi_cs(spi_cs), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .bus(spi_bus)
    );

    cmd_decoder i_decoder (
        .clk(clk), .reset(reset), .bus(spi_bus), .col(col_bus),
        .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
    );

    pov_regs i_regs (
        .clk(clk), .reset(reset),
        .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .display_enable(display_enable), .gclk_div(gclk_div)
    );

    led_shift_ctrl i_shift (
        .clk(clk), .reset(reset),
        .display_enable(display_enable), .gclk_div(gclk_div), .col(col_bus),
        .drv_sin(drv_sin), .drv_sclk(drv_sclk), .drv_lat(drv_lat),
        .drv_gclk(drv_gclk), .drv_blank(drv_blank), .col_sel(col_sel)
    );

endmodule

`default_nettype wire

//--- led_shift_ctrl.sv
// *************************************************
// Buffers column words, shifts them into the LED
// driver chain, latches and selects the column
// Also makes the grayscale clock and blanking
// *************************************************
`timescale 1ns/1ns
`default_nettype none
`include "pov_config.svh"

module led_shift_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              display_enable,
    input  pov_pkg::byte_t    gclk_div,
    col_data_if.sink          col,
    output logic              drv_sin,
    output logic              drv_sclk,
    output logic              drv_lat,
    output logic              drv_gclk,
    output logic              drv_blank,
    output pov_pkg::col_idx_t col_sel
);

    localparam int PW = $clog2(`POV_CREDITS);
    localparam int CW = $clog2(`POV_CREDITS + 1);
    localparam int BW = $clog2(`POV_COL_BITS);

    pov_pkg::pixel_t       fifo_data [`POV_CREDITS];
    pov_pkg::col_idx_t     fifo_col  [`POV_CREDITS];
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [CW-1:0]         count;
    logic                  pop;
    pov_pkg::shift_state_t state;
    pov_pkg::pixel_t       shreg;
    pov_pkg::col_idx_t     col_pend;
    logic [BW-1:0]         bit_cnt;
    logic                  phase;
    pov_pkg::byte_t        gclk_cnt;

    // Head word leaves as soon as the shifter is free
    assign pop               = state == pov_pkg::SH_IDLE && count != '0;
    assign col.credit_return = pop;

    always_ff @(posedge clk) begin
        if (col.valid) begin
            fifo_data[wr_ptr] <= col.data;
            fifo_col[wr_ptr]  <= col.col;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (col.valid)
                wr_ptr <= (wr_ptr == PW'(`POV_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(`POV_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(col.valid) - CW'(pop);
        end
    end

    // Each bit takes two clocks with sclk high in the second
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= pov_pkg::SH_IDLE;
            col_sel <= '0;
            phase   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            case (state)
                pov_pkg::SH_IDLE: begin
                    phase   <= 1'b0;
                    bit_cnt <= '0;
                    if (pop)
                        state <= pov_pkg::SH_SHIFT;
                end
                pov_pkg::SH_SHIFT: begin
                    phase <= ~phase;
                    if (phase && bit_cnt == BW'(`POV_COL_BITS - 1)) begin
                        // Column switches together with the latch
                        state   <= pov_pkg::SH_LATCH;
                        col_sel <= col_pend;
                    end else if (phase) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= pov_pkg::SH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shreg    <= fifo_data[rd_ptr];
            col_pend <= fifo_col[rd_ptr];
        end else if (state == pov_pkg::SH_SHIFT && phase) begin
            shreg <= shreg << 1;
        end
    end

    // MSB first
    assign drv_sin  = state == pov_pkg::SH_SHIFT && shreg[`POV_COL_BITS-1];
    assign drv_sclk = state == pov_pkg::SH_SHIFT && phase;
    assign drv_lat  = state == pov_pkg::SH_LATCH;

    // Grayscale clock toggles every gclk_div + 1 clocks while enabled
    always_ff @(posedge clk) begin
        if (reset) begin
            gclk_cnt  <= '0;
            drv_gclk  <= 1'b0;
            drv_blank <= 1'b1;
        end else begin
            drv_blank <= ~display_enable;
            if (!display_enable) begin
                gclk_cnt <= '0;
                drv_gclk <= 1'b0;
            end else if (gclk_cnt == gclk_div) begin
                gclk_cnt <= '0;
                drv_gclk <= ~drv_gclk;
            end else begin
                gclk_cnt <= gclk_cnt + 8'd1;
            end
        end
    end

    // Decoder credits must keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        col.valid |-> count != CW'(`POV_CREDITS));

endmodule

`default_nettype wire

//--- pov_regs.sv
// *************************************************
// Display control registers written and read back
// by the command decoder
// *************************************************
`timescale 1ns/1ns
`default_nettype none
`include "pov_config.svh"

module pov_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               reg_wr,
    input  pov_pkg::reg_addr_t reg_addr,
    input  pov_pkg::byte_t     reg_wdata,
    output pov_pkg::byte_t     reg_rdata,
    output logic               display_enable,
    output pov_pkg::byte_t     gclk_div
);

    // Display starts blanked with the default divider
    always_ff @(posedge clk) begin
        if (reset) begin
            display_enable <= 1'b0;
            gclk_div       <= 8'(`POV_GCLK_DIV_RST);
        end else if (reg_wr) begin
            case (reg_addr)
                pov_pkg::REG_CTRL:     display_enable <= reg_wdata[0];
                pov_pkg::REG_GCLK_DIV: gclk_div       <= reg_wdata;
                default: ;
            endcase
        end
    end

    // Readback mux
    // Unmapped addresses return zero
    always_comb begin
        case (reg_addr)
            pov_pkg::REG_CTRL:     reg_rdata = {7'b0, display_enable};
            pov_pkg::REG_GCLK_DIV: reg_rdata = gclk_div;
            default:               reg_rdata = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- cmd_decoder.sv
// *************************************************
// Turns SPI frames into register accesses and into
// credited column words for the shift controller
// *************************************************
`timescale 1ns/1ns
`default_nettype none
`include "pov_config.svh"

module cmd_decoder (
    input  logic               clk,
    input  logic               reset,
    spi_byte_if.dec            bus,
    col_data_if.src            col,
    output logic               reg_wr,
    output pov_pkg::reg_addr_t reg_addr,
    output pov_pkg::byte_t     reg_wdata,
    input  pov_pkg::byte_t     reg_rdata
);

    localparam int CW = $clog2(`POV_CREDITS + 1);

    pov_pkg::dec_state_t state;
    logic [CW-1:0]       credits;
    logic [1:0]          byte_cnt;
    logic                hold;
    logic                rd_pend;
    pov_pkg::col_idx_t   col_q;
    pov_pkg::pixel_t     data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= pov_pkg::DEC_IDLE;
            hold    <= 1'b0;
            reg_wr  <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            reg_wr  <= 1'b0;
            rd_pend <= 1'b0;
            if (col.valid)
                hold <= 1'b0;
            // Any frame edge restarts the parser
            if (bus.frame_end || bus.frame_start) begin
                state <= pov_pkg::DEC_IDLE;
            end else if (bus.rx_valid) begin
                case (state)
                    pov_pkg::DEC_IDLE: begin
                        case (pov_pkg::spi_op_t'(bus.rx_byte))
                            pov_pkg::REG_WRITE: state <= pov_pkg::DEC_ADDR;
                            pov_pkg::REG_READ:  state <= pov_pkg::DEC_READ_REPLY;
                            // Drop the column frame while a word still waits
                            pov_pkg::COL_WRITE:
                                state <= hold ? pov_pkg::DEC_SKIP : pov_pkg::DEC_COL_IDX;
                            default:            state <= pov_pkg::DEC_SKIP;
                        endcase
                    end
                    pov_pkg::DEC_ADDR: state <= pov_pkg::DEC_DATA;
                    pov_pkg::DEC_DATA: begin
                        reg_wr <= 1'b1;
                        state  <= pov_pkg::DEC_SKIP;
                    end
                    // Reply loads the cycle after the address settles
                    pov_pkg::DEC_READ_REPLY: begin
                        rd_pend <= 1'b1;
                        state   <= pov_pkg::DEC_SKIP;
                    end
                    pov_pkg::DEC_COL_IDX: begin
                        byte_cnt <= '0;
                        state    <= pov_pkg::DEC_COL_BYTES;
                    end
                    pov_pkg::DEC_COL_BYTES: begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd2) begin
                            hold  <= 1'b1;
                            state <= pov_pkg::DEC_SKIP;
                        end
                    end
                    default: state <= pov_pkg::DEC_SKIP;
                endcase
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (bus.rx_valid) begin
            if (state == pov_pkg::DEC_ADDR || state == pov_pkg::DEC_READ_REPLY)
                reg_addr <= bus.rx_byte;
            if (state == pov_pkg::DEC_DATA)
                reg_wdata <= bus.rx_byte;
            if (state == pov_pkg::DEC_COL_IDX)
                col_q <= pov_pkg::col_idx_t'(bus.rx_byte);
            // Red first, blue last
            if (state == pov_pkg::DEC_COL_BYTES)
                data_q <= {data_q[`POV_COL_BITS-9:0], bus.rx_byte};
        end
    end

    // One credit per word in flight
    always_ff @(posedge clk) begin
        if (reset)
            credits <= CW'(`POV_CREDITS);
        else
            credits <= credits - CW'(col.valid) + CW'(col.credit_return);
    end

    assign col.valid   = hold && credits != '0;
    assign col.col     = col_q;
    assign col.data    = data_q;
    assign bus.tx_load = rd_pend;
    assign bus.tx_byte = reg_rdata;

    // Shifter must never return more credits than were spent
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credits <= CW'(`POV_CREDITS));

endmodule

`default_nettype wire

//--- spi_frame_rx.sv
// *************************************************
// SPI mode 0 slave on the system clock
// Pins are synchronized and edge detected here and
// bytes go to the decoder over spi_byte_if
// *************************************************
`timescale 1ns/1ns
`default_nettype none

module spi_frame_rx (
    input  logic     clk,
    input  logic     reset,
    input  logic     spi_sclk,
    input  logic     spi_cs,
    input  logic     spi_mosi,
    output logic     spi_miso,
    spi_byte_if.rx   bus
);

    logic [1:0]     sclk_sync;
    logic [1:0]     cs_sync;
    logic [1:0]     mosi_sync;
    logic           sclk_d;
    logic           cs_d;
    logic           sclk_rise;
    logic           sclk_fall;
    logic [2:0]     bit_cnt;
    pov_pkg::byte_t rx_shift;
    pov_pkg::byte_t tx_shift;

    // Two-flop synchronizers plus one delay stage for edges
    // Chip select idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sclk_d    <= 1'b0;
            cs_d      <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            cs_sync   <= {cs_sync[0], spi_cs};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_d    <= sclk_sync[1];
            cs_d      <= cs_sync[1];
        end
    end

    // Clock edges only count inside a frame
    assign sclk_rise = sclk_sync[1] & ~sclk_d & ~cs_sync[1];
    assign sclk_fall = ~sclk_sync[1] & sclk_d & ~cs_sync[1];

    // Bit counter and frame marks
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt         <= '0;
            bus.rx_valid    <= 1'b0;
            bus.frame_start <= 1'b0;
            bus.frame_end   <= 1'b0;
        end else begin
            bus.rx_valid    <= 1'b0;
            bus.frame_start <= ~cs_sync[1] & cs_d;
            bus.frame_end   <= cs_sync[1] & ~cs_d;
            if (cs_sync[1]) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                // Eighth bit completes the byte
                if (bit_cnt == 3'd7)
                    bus.rx_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise)
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
    end

    assign bus.rx_byte = rx_shift;

    // Reply shifter
    // A load lands between bytes and beats the clear at the byte end
    // No shift on the fall after the last bit so the new MSB shows first
    always_ff @(posedge clk) begin
        if (reset)
            tx_shift <= '0;
        else if (bus.tx_load)
            tx_shift <= bus.tx_byte;
        else if (bus.rx_valid || bus.frame_start)
            tx_shift <= '0;
        else if (sclk_fall && bit_cnt != 3'd0)
            tx_shift <= {tx_shift[6:0], 1'b0};
    end

    assign spi_miso = tx_shift[7];

    // No byte may complete outside a frame
    a_rx_in_frame: assert property (@(posedge clk) disable iff (reset)
        bus.rx_valid |-> !cs_sync[1]);

endmodule

`default_nettype wire

//--- col_data_if.sv
// *************************************************
// Credited column word channel from the command
// decoder into the shift controller buffer
// *************************************************
`timescale 1ns/1ns
`default_nettype none

interface col_data_if;

    // One beat per column word, only sent while a credit is held
    logic                valid;
    pov_pkg::col_idx_t   col;
    pov_pkg::pixel_t     data;

    // Pulses once per word taken out of the buffer
    logic                credit_return;

    modport src  (output valid, col, data, input credit_return);
    modport sink (input valid, col, data, output credit_return);

endinterface

`default_nettype wire

//--- spi_byte_if.sv
// *************************************************
// Byte stream between the SPI slave and the command
// decoder, with frame marks and the reply byte
// *************************************************
`timescale 1ns/1ns
`default_nettype none

interface spi_byte_if;

    // Receive side, all single-cycle pulses except the byte itself
    logic                frame_start;
    logic                frame_end;
    logic                rx_valid;
    pov_pkg::byte_t      rx_byte;

    // Reply byte, sent during the next byte of the frame
    logic                tx_load;
    pov_pkg::byte_t      tx_byte;

    modport rx  (output frame_start, frame_end, rx_valid, rx_byte, input tx_load, tx_byte);
    modport dec (input frame_start, frame_end, rx_valid, rx_byte, output tx_load, tx_byte);

endinterface

`default_nettype wire

//--- pov_pkg.sv
// *************************************************
// Shared types, opcodes and register map of the
// POV column controller, referenced by scoped names
// *************************************************
`default_nettype none
`include "pov_config.svh"

package pov_pkg;

    typedef logic [`POV_COL_BITS-1:0]         pixel_t;
    typedef logic [$clog2(`POV_NUM_COLS)-1:0] col_idx_t;
    typedef logic [7:0]                       byte_t;
    typedef logic [7:0]                       reg_addr_t;

    // First byte of every SPI frame
    typedef enum logic [7:0] {
        REG_WRITE = 8'h01,
        REG_READ  = 8'h02,
        COL_WRITE = 8'h03
    } spi_op_t;

    // Command decoder states
    typedef enum logic [2:0] {
        DEC_IDLE, DEC_ADDR, DEC_DATA, DEC_READ_REPLY, DEC_COL_IDX, DEC_COL_BYTES, DEC_SKIP
    } dec_state_t;

    // Shift controller states
    typedef enum logic [1:0] {SH_IDLE, SH_SHIFT, SH_LATCH} shift_state_t;

    // Register map
    localparam reg_addr_t REG_CTRL     = 8'h00;
    localparam reg_addr_t REG_GCLK_DIV = 8'h01;

endpackage

`default_nettype wire

//--- pov_config.svh
// *************************************************
// Build-time sizes for the POV column controller
// Include in any file that needs a width or depth
// *************************************************
`ifndef POV_CONFIG_SVH
`define POV_CONFIG_SVH

// Column word width in bits (8 red, 8 green, 8 blue)
`define POV_COL_BITS 24

// Columns on the multiplexer
`define POV_NUM_COLS 8

// Depth of the shifter column buffer and initial decoder credits
`define POV_CREDITS 4

// Grayscale clock divider value after reset
`define POV_GCLK_DIV_RST 3

`endif
